// File: Bender.yml
package:
  name: soc_io

sources:
  - files:
      - rtl/soc_io_pkg.sv
      - rtl/wb8_if.sv
      - rtl/reset_hold.sv
      - rtl/wb8_decoder.sv
      - rtl/ram_wb8.sv
      - rtl/leds_wb8.sv
      - rtl/uart_wb8.sv
      - rtl/soc_io_top.sv
  - target: test
    files:
      - tb/tb_soc_io_top.sv

// File: rtl/leds_wb8.sv
`default_nettype none

module leds_wb8 (
    input  wire logic                          clk,
    input  wire logic                          rst_n_i,
    wb8_if.slave                               bus_i,
    output logic [soc_io_pkg::DATA_W-1:0]      leds_o
);

    logic [soc_io_pkg::DATA_W-1:0] leds_q;
    logic                          ack_q;
    logic                          access;

    // address is don't care, whole region maps here
    assign access = bus_i.stb && !ack_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            leds_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && bus_i.we) begin
                leds_q <= bus_i.dat_w;
            end
        end
    end

    assign bus_i.dat_r = leds_q;
    assign bus_i.ack   = ack_q;
    assign leds_o      = leds_q;

endmodule

`default_nettype wire

// File: rtl/ram_wb8.sv
`default_nettype none

module ram_wb8 (
    input  wire logic clk,
    input  wire logic rst_n_i,
    wb8_if.slave      bus_i
);

    localparam int DEPTH = 2 ** soc_io_pkg::RAM_ADDR_W;

    logic [soc_io_pkg::DATA_W-1:0]     mem [DEPTH];
    logic [soc_io_pkg::DATA_W-1:0]     rd_q;
    logic [soc_io_pkg::RAM_ADDR_W-1:0] addr;
    logic                              ack_q;
    logic                              access;

    // upper address bits ignored, so the 1 KiB repeats
    assign addr   = bus_i.adr[soc_io_pkg::RAM_ADDR_W-1:0];
    assign access = bus_i.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus_i.we) begin
                mem[addr] <= bus_i.dat_w;
            end
            rd_q <= mem[addr];
        end
    end

    // one cycle ack per strobe
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign bus_i.dat_r = rd_q;
    assign bus_i.ack   = ack_q;

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_q |=> !ack_q);

endmodule

`default_nettype wire

// File: rtl/reset_hold.sv
`default_nettype none

module reset_hold (
    input  wire logic clk,
    input  wire logic rst_n_i,
    output logic      rst_n_o,
    output logic      ready_o
);

    logic [soc_io_pkg::HOLD_CNT_W-1:0] hold_cnt;
    logic                              ready_q;

    // block RAM reads back garbage for a while after configuration,
    // so the rest of the design stays in reset until this runs out
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_cnt <= '0;
            ready_q  <= 1'b0;
        end else if (!ready_q) begin
            hold_cnt <= hold_cnt + 1'b1;
            if (hold_cnt == soc_io_pkg::HOLD_LAST) begin
                ready_q <= 1'b1;
            end
        end
    end

    // asserted async, released on a clock edge
    assign rst_n_o = ready_q;
    assign ready_o = ready_q;

endmodule

`default_nettype wire

// File: rtl/soc_io_pkg.sv
`default_nettype none

package soc_io_pkg;

    // bus geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 8;
    localparam int RAM_ADDR_W = 10;

    // address map, bits 31:28 pick the region and 27:24 the I/O device
    localparam logic [3:0] IO_REGION   = 4'hF;
    localparam logic [3:0] UART_DEVICE = 4'h0;

    // uart bit timing, kept short for simulation
    localparam int CLKS_PER_BIT = 8;
    localparam int UART_CNT_W   = $clog2(CLKS_PER_BIT);
    localparam logic [UART_CNT_W-1:0] BIT_LAST  = UART_CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [UART_CNT_W-1:0] HALF_LAST = UART_CNT_W'(CLKS_PER_BIT / 2 - 1);

    // internal reset stretch after external release
    localparam int RESET_HOLD = 16;
    localparam int HOLD_CNT_W = $clog2(RESET_HOLD);
    localparam logic [HOLD_CNT_W-1:0] HOLD_LAST = HOLD_CNT_W'(RESET_HOLD - 1);

    // uart status register bits
    localparam int STAT_TX_BUSY      = 0;
    localparam int STAT_RX_VALID     = 1;
    localparam int STAT_RX_FRAME_ERR = 2;

    typedef enum logic [7:0] {
        DEV_RAM  = 8'd0,
        DEV_LEDS = 8'd1,
        DEV_UART = 8'd2
    } dev_sel_e;

    typedef enum logic [1:0] {
        UART_REG_DATA   = 2'd0,
        UART_REG_STATUS = 2'd1
    } uart_reg_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } uart_rx_state_e;

endpackage

`default_nettype wire

// File: rtl/soc_io_top.sv
`default_nettype none

module soc_io_top (
    input  wire logic                          clk,
    input  wire logic                          rst_n_i,
    input  wire logic [soc_io_pkg::ADDR_W-1:0] wb_adr_i,
    input  wire logic [soc_io_pkg::DATA_W-1:0] wb_dat_i,
    output logic      [soc_io_pkg::DATA_W-1:0] wb_dat_o,
    input  wire logic                          wb_cyc_i,
    input  wire logic                          wb_stb_i,
    input  wire logic                          wb_we_i,
    output logic                               wb_ack_o,
    output logic      [soc_io_pkg::DATA_W-1:0] leds_o,
    output logic                               uart_tx_o,
    input  wire logic                          uart_rx_i,
    output logic                               ready_o
);

    logic rst_n;
    logic ready;

    wb8_if cpu_bus ();
    wb8_if ram_bus ();
    wb8_if leds_bus ();
    wb8_if uart_bus ();

    reset_hold u_reset_hold (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .rst_n_o (rst_n),
        .ready_o (ready)
    );

    // no strobe reaches the slaves until the reset hold is over
    assign cpu_bus.adr   = wb_adr_i;
    assign cpu_bus.dat_w = wb_dat_i;
    assign cpu_bus.we    = wb_we_i;
    assign cpu_bus.stb   = wb_cyc_i && wb_stb_i && ready;
    assign wb_dat_o      = cpu_bus.dat_r;
    assign wb_ack_o      = cpu_bus.ack;
    assign ready_o       = ready;

    wb8_decoder u_decoder (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .master_i (cpu_bus.slave),
        .ram_o    (ram_bus.master),
        .leds_o   (leds_bus.master),
        .uart_o   (uart_bus.master)
    );

    ram_wb8 u_ram (
        .clk     (clk),
        .rst_n_i (rst_n),
        .bus_i   (ram_bus.slave)
    );

    leds_wb8 u_leds (
        .clk     (clk),
        .rst_n_i (rst_n),
        .bus_i   (leds_bus.slave),
        .leds_o  (leds_o)
    );

    uart_wb8 u_uart (
        .clk     (clk),
        .rst_n_i (rst_n),
        .bus_i   (uart_bus.slave),
        .tx_o    (uart_tx_o),
        .rx_i    (uart_rx_i)
    );

endmodule

`default_nettype wire

// File: rtl/uart_wb8.sv
`default_nettype none

module uart_wb8 (
    input  wire logic clk,
    input  wire logic rst_n_i,
    wb8_if.slave      bus_i,
    output logic      tx_o,
    input  wire logic rx_i
);

    soc_io_pkg::uart_reg_e      reg_sel;
    soc_io_pkg::uart_tx_state_e tx_state;
    soc_io_pkg::uart_rx_state_e rx_state;

    logic                              ack_q;
    logic                              access;
    logic [soc_io_pkg::DATA_W-1:0]     rd_q;
    logic [soc_io_pkg::DATA_W-1:0]     status;

    logic [7:0]                        tx_shift;
    logic [2:0]                        tx_bit_cnt;
    logic [soc_io_pkg::UART_CNT_W-1:0] tx_clk_cnt;
    logic                              tx_start;
    logic                              tx_busy;

    logic [1:0]                        rx_sync;
    logic                              rx_s;
    logic [7:0]                        rx_shift;
    logic [7:0]                        rx_data;
    logic [2:0]                        rx_bit_cnt;
    logic [soc_io_pkg::UART_CNT_W-1:0] rx_clk_cnt;
    logic                              rx_valid;
    logic                              rx_ferr;
    logic                              rx_clear;

    assign reg_sel  = soc_io_pkg::uart_reg_e'(bus_i.adr[1:0]);
    assign access   = bus_i.stb && !ack_q;
    assign tx_busy  = (tx_state != soc_io_pkg::TX_IDLE);
    // writes while busy still get an ack, the byte is lost
    assign tx_start = access && bus_i.we && (reg_sel == soc_io_pkg::UART_REG_DATA) && !tx_busy;
    assign rx_clear = access && !bus_i.we && (reg_sel == soc_io_pkg::UART_REG_DATA);

    always_comb begin
        status = '0;
        status[soc_io_pkg::STAT_TX_BUSY]      = tx_busy;
        status[soc_io_pkg::STAT_RX_VALID]     = rx_valid;
        status[soc_io_pkg::STAT_RX_FRAME_ERR] = rx_ferr;
    end

    // read data captured with the ack
    always_ff @(posedge clk) begin
        if (access) begin
            case (reg_sel)
                soc_io_pkg::UART_REG_DATA:   rd_q <= rx_data;
                soc_io_pkg::UART_REG_STATUS: rd_q <= status;
                default:                     rd_q <= '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // transmitter, start bit, 8 data bits lsb first, stop bit
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_state   <= soc_io_pkg::TX_IDLE;
            tx_shift   <= '0;
            tx_bit_cnt <= '0;
            tx_clk_cnt <= '0;
            tx_o       <= 1'b1;
        end else begin
            case (tx_state)
                soc_io_pkg::TX_IDLE: begin
                    if (tx_start) begin
                        tx_shift   <= bus_i.dat_w;
                        tx_clk_cnt <= '0;
                        tx_o       <= 1'b0;
                        tx_state   <= soc_io_pkg::TX_START;
                    end
                end
                soc_io_pkg::TX_START: begin
                    tx_clk_cnt <= tx_clk_cnt + 1'b1;
                    if (tx_clk_cnt == soc_io_pkg::BIT_LAST) begin
                        tx_clk_cnt <= '0;
                        tx_bit_cnt <= '0;
                        tx_o       <= tx_shift[0];
                        tx_state   <= soc_io_pkg::TX_DATA;
                    end
                end
                soc_io_pkg::TX_DATA: begin
                    tx_clk_cnt <= tx_clk_cnt + 1'b1;
                    if (tx_clk_cnt == soc_io_pkg::BIT_LAST) begin
                        tx_clk_cnt <= '0;
                        tx_shift   <= tx_shift >> 1;
                        tx_bit_cnt <= tx_bit_cnt + 1'b1;
                        if (tx_bit_cnt == 3'd7) begin
                            tx_o     <= 1'b1;
                            tx_state <= soc_io_pkg::TX_STOP;
                        end else begin
                            tx_o <= tx_shift[1];
                        end
                    end
                end
                default: begin
                    tx_clk_cnt <= tx_clk_cnt + 1'b1;
                    if (tx_clk_cnt == soc_io_pkg::BIT_LAST) begin
                        tx_clk_cnt <= '0;
                        tx_state   <= soc_io_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    // rx line is asynchronous, two flops before use
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx_i};
        end
    end

    assign rx_s = rx_sync[1];

    // receiver samples every bit at its middle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_state   <= soc_io_pkg::RX_IDLE;
            rx_shift   <= '0;
            rx_data    <= '0;
            rx_bit_cnt <= '0;
            rx_clk_cnt <= '0;
            rx_valid   <= 1'b0;
            rx_ferr    <= 1'b0;
        end else begin
            if (rx_clear) begin
                rx_valid <= 1'b0;
                rx_ferr  <= 1'b0;
            end
            case (rx_state)
                soc_io_pkg::RX_IDLE: begin
                    rx_clk_cnt <= '0;
                    if (!rx_s) begin
                        rx_state <= soc_io_pkg::RX_START;
                    end
                end
                soc_io_pkg::RX_START: begin
                    rx_clk_cnt <= rx_clk_cnt + 1'b1;
                    if (rx_clk_cnt == soc_io_pkg::HALF_LAST) begin
                        rx_clk_cnt <= '0;
                        rx_bit_cnt <= '0;
                        // glitch shorter than half a bit goes back to idle
                        rx_state   <= rx_s ? soc_io_pkg::RX_IDLE : soc_io_pkg::RX_DATA;
                    end
                end
                soc_io_pkg::RX_DATA: begin
                    rx_clk_cnt <= rx_clk_cnt + 1'b1;
                    if (rx_clk_cnt == soc_io_pkg::BIT_LAST) begin
                        rx_clk_cnt <= '0;
                        rx_shift   <= {rx_s, rx_shift[7:1]};
                        rx_bit_cnt <= rx_bit_cnt + 1'b1;
                        if (rx_bit_cnt == 3'd7) begin
                            rx_state <= soc_io_pkg::RX_STOP;
                        end
                    end
                end
                default: begin
                    rx_clk_cnt <= rx_clk_cnt + 1'b1;
                    if (rx_clk_cnt == soc_io_pkg::BIT_LAST) begin
                        rx_data  <= rx_shift;
                        rx_valid <= 1'b1;
                        rx_ferr  <= !rx_s;
                        rx_state <= soc_io_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

    assign bus_i.dat_r = rd_q;
    assign bus_i.ack   = ack_q;

    a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n_i)
        (tx_state == soc_io_pkg::TX_IDLE) |-> tx_o);

endmodule

`default_nettype wire

// File: rtl/wb8_decoder.sv
`default_nettype none

module wb8_decoder (
    input  wire logic clk,
    input  wire logic rst_n_i,
    wb8_if.slave      master_i,
    wb8_if.master     ram_o,
    wb8_if.master     leds_o,
    wb8_if.master     uart_o
);

    soc_io_pkg::dev_sel_e dev_sel;

    // 0xF0xxxxxx uart, other 0xFxxxxxxx leds, rest is ram
    always_comb begin
        if (master_i.adr[31:28] == soc_io_pkg::IO_REGION) begin
            if (master_i.adr[27:24] == soc_io_pkg::UART_DEVICE) begin
                dev_sel = soc_io_pkg::DEV_UART;
            end else begin
                dev_sel = soc_io_pkg::DEV_LEDS;
            end
        end else begin
            dev_sel = soc_io_pkg::DEV_RAM;
        end
    end

    // shared request fields go to every slave
    assign ram_o.adr    = master_i.adr;
    assign ram_o.dat_w  = master_i.dat_w;
    assign ram_o.we     = master_i.we;
    assign leds_o.adr   = master_i.adr;
    assign leds_o.dat_w = master_i.dat_w;
    assign leds_o.we    = master_i.we;
    assign uart_o.adr   = master_i.adr;
    assign uart_o.dat_w = master_i.dat_w;
    assign uart_o.we    = master_i.we;

    // only the selected slave sees a strobe
    assign ram_o.stb  = master_i.stb && (dev_sel == soc_io_pkg::DEV_RAM);
    assign leds_o.stb = master_i.stb && (dev_sel == soc_io_pkg::DEV_LEDS);
    assign uart_o.stb = master_i.stb && (dev_sel == soc_io_pkg::DEV_UART);

    // return path
    always_comb begin
        case (dev_sel)
            soc_io_pkg::DEV_UART: begin
                master_i.dat_r = uart_o.dat_r;
                master_i.ack   = uart_o.ack;
            end
            soc_io_pkg::DEV_LEDS: begin
                master_i.dat_r = leds_o.dat_r;
                master_i.ack   = leds_o.ack;
            end
            default: begin
                master_i.dat_r = ram_o.dat_r;
                master_i.ack   = ram_o.ack;
            end
        endcase
    end

    a_one_slave_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({ram_o.stb, leds_o.stb, uart_o.stb}));

    // an ack must answer a strobe seen on the previous edge
    a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
        master_i.ack |-> $past(master_i.stb));

endmodule

`default_nettype wire

// File: rtl/wb8_if.sv
`default_nettype none

// single master 8-bit bus, one transfer in flight
interface wb8_if;

    logic [soc_io_pkg::ADDR_W-1:0] adr;
    logic [soc_io_pkg::DATA_W-1:0] dat_w;
    logic [soc_io_pkg::DATA_W-1:0] dat_r;
    logic                          stb;
    logic                          we;
    logic                          ack;

    modport master (
        output adr,
        output dat_w,
        output stb,
        output we,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  adr,
        input  dat_w,
        input  stb,
        input  we,
        output dat_r,
        output ack
    );

endinterface

`default_nettype wire

// File: soc_io_top.f
rtl/soc_io_pkg.sv
rtl/wb8_if.sv
rtl/reset_hold.sv
rtl/wb8_decoder.sv
rtl/ram_wb8.sv
rtl/leds_wb8.sv
rtl/uart_wb8.sv
rtl/soc_io_top.sv
tb/tb_soc_io_top.sv

// File: tb/tb_soc_io_top.sv
`default_nettype none

module tb_soc_io_top;

    localparam int NROWS        = 26;
    localparam int ACK_LIMIT    = 4;
    localparam int FRAME_CYCLES = 10 * soc_io_pkg::CLKS_PER_BIT;
    localparam logic [31:0] UART_DATA = 32'hF000_0000;
    localparam logic [31:0] UART_STAT = 32'hF000_0001;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_STAT, OP_WAIT, OP_HOLD, OP_LEDS} op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] adr;
        logic [7:0]  wdat;
        logic [7:0]  exp;
    } row_t;

    logic                          clk;
    logic                          rst_n;
    logic [soc_io_pkg::ADDR_W-1:0] wb_adr;
    logic [soc_io_pkg::DATA_W-1:0] wb_dat_w;
    logic [soc_io_pkg::DATA_W-1:0] wb_dat_r;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic                          wb_ack;
    logic [soc_io_pkg::DATA_W-1:0] leds;
    logic                          uart_tx;
    logic                          ready;

    row_t rows [NROWS];
    int   n_rows;
    int   checks;
    int   errors;

    // uart loops back onto its own receiver
    soc_io_top UUT (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .wb_adr_i  (wb_adr),
        .wb_dat_i  (wb_dat_w),
        .wb_dat_o  (wb_dat_r),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_ack_o  (wb_ack),
        .leds_o    (leds),
        .uart_tx_o (uart_tx),
        .uart_rx_i (uart_tx),
        .ready_o   (ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (NROWS * 12 * soc_io_pkg::CLKS_PER_BIT + 200) @(posedge clk);
        $display("watchdog expired before the table finished");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string op_text(input op_e op);
        case (op)
            OP_WR:   return "write";
            OP_RD:   return "read";
            OP_STAT: return "status";
            OP_WAIT: return "wait";
            OP_HOLD: return "hold";
            default: return "leds";
        endcase
    endfunction

    task automatic check_byte(input logic [soc_io_pkg::DATA_W-1:0] got,
                              input logic [soc_io_pkg::DATA_W-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input logic [soc_io_pkg::DATA_W-1:0] got,
                                input logic [soc_io_pkg::DATA_W-1:0] exp);
        checks++;
        if (got[soc_io_pkg::STAT_TX_BUSY] !== exp[soc_io_pkg::STAT_TX_BUSY] ||
            got[soc_io_pkg::STAT_RX_VALID] !== exp[soc_io_pkg::STAT_RX_VALID] ||
            got[soc_io_pkg::STAT_RX_FRAME_ERR] !== exp[soc_io_pkg::STAT_RX_FRAME_ERR]) begin
            errors++;
            $display("Error: %0t: status busy/valid/frame_err %b%b%b, expected %b%b%b", $time,
                     got[soc_io_pkg::STAT_TX_BUSY], got[soc_io_pkg::STAT_RX_VALID],
                     got[soc_io_pkg::STAT_RX_FRAME_ERR], exp[soc_io_pkg::STAT_TX_BUSY],
                     exp[soc_io_pkg::STAT_RX_VALID], exp[soc_io_pkg::STAT_RX_FRAME_ERR]);
        end
    endtask

    task automatic check_ack_latency(input int cycles);
        checks++;
        if (cycles != 1) begin
            errors++;
            $display("Error: %0t: ack came %0d cycles after stb, expected 1", $time, cycles);
        end
    endtask

    // one transfer driven just after the edge with ack sampled just after the next
    task automatic bus_xfer(input logic we, input logic [31:0] adr, input logic [7:0] wdat,
                            output logic [7:0] rdat);
        int   lat;
        logic acked;
        @(posedge clk);
        #2;
        wb_adr   = adr;
        wb_dat_w = wdat;
        wb_we    = we;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        lat      = 0;
        acked    = 1'b0;
        while (!acked && lat < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            lat++;
            acked = wb_ack;
        end
        rdat = wb_dat_r;
        if (acked) begin
            check_ack_latency(lat);
        end else begin
            errors++;
            $display("no acknowledge within %0d cycles for address %h", ACK_LIMIT, adr);
        end
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic add_row(input op_e op, input logic [31:0] adr, input logic [7:0] wdat,
                           input logic [7:0] exp);
        rows[n_rows] = '{op: op, adr: adr, wdat: wdat, exp: exp};
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0] rng;
        logic [7:0]  rnd [4];
        rng = 32'he7a3;
        for (int k = 0; k < 4; k++) begin
            rng    = xorshift32(rng);
            rnd[k] = rng[7:0];
        end
        n_rows = 0;
        add_row(OP_WR, 32'h0000_0010, rnd[0], 8'h00);
        add_row(OP_WR, 32'h0000_03FF, rnd[1], 8'h00);
        add_row(OP_WR, 32'h1234_5678, rnd[2], 8'h00);
        add_row(OP_WR, 32'h0000_0200, rnd[3], 8'h00);
        add_row(OP_RD, 32'h0000_0010, 8'h00, rnd[0]);
        add_row(OP_RD, 32'h0000_03FF, 8'h00, rnd[1]);
        add_row(OP_RD, 32'h1234_5678, 8'h00, rnd[2]);
        add_row(OP_RD, 32'h0000_0200, 8'h00, rnd[3]);
        // aliased reads differ only above bit 9
        add_row(OP_RD, 32'h0000_0410, 8'h00, rnd[0]);
        add_row(OP_RD, 32'hEFFF_FFFF, 8'h00, rnd[1]);
        add_row(OP_WR, 32'hF100_0000, 8'hA5, 8'h00);
        add_row(OP_LEDS, 32'h0, 8'h00, 8'hA5);
        add_row(OP_RD, 32'hF100_0000, 8'h00, 8'hA5);
        add_row(OP_RD, 32'hF700_0010, 8'h00, 8'hA5);
        add_row(OP_WR, 32'h0000_0000, 8'h3C, 8'h00);
        add_row(OP_LEDS, 32'h0, 8'h00, 8'hA5);
        // loopback of a single byte
        add_row(OP_WR, UART_DATA, 8'h96, 8'h00);
        add_row(OP_STAT, UART_STAT, 8'h00, 8'h01);
        add_row(OP_WAIT, UART_STAT, 8'h00, 8'h02);
        add_row(OP_RD, UART_DATA, 8'h00, 8'h96);
        add_row(OP_STAT, UART_STAT, 8'h00, 8'h00);
        // second write lands while the first frame is still going out
        add_row(OP_WR, UART_DATA, 8'h5A, 8'h00);
        add_row(OP_WR, UART_DATA, 8'hC3, 8'h00);
        add_row(OP_WAIT, UART_STAT, 8'h00, 8'h02);
        add_row(OP_RD, UART_DATA, 8'h00, 8'h5A);
        add_row(OP_HOLD, UART_STAT, 8'h00, 8'h00);
    endtask

    task automatic check_reset_sequence();
        int cycles;
        int err0;
        err0 = errors;
        repeat (5) @(posedge clk);
        #1;
        check_level(ready, 1'b0, "ready_o in reset");
        check_byte(leds, '0, "leds_o in reset");
        check_level(uart_tx, 1'b1, "uart_tx_o in reset");
        #1;
        rst_n  = 1'b1;
        cycles = 0;
        while (!ready && cycles <= 2 * soc_io_pkg::RESET_HOLD) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        checks++;
        if (cycles != soc_io_pkg::RESET_HOLD) begin
            errors++;
            $display("Error: %0t: ready_o rose %0d cycles after release, expected %0d",
                     $time, cycles, soc_io_pkg::RESET_HOLD);
        end
        $display("reset sequence: %s", (errors == err0) ? "ok" : "mismatch");
    endtask

    task automatic apply_row(input int idx);
        row_t        r;
        logic [7:0]  rdat;
        logic        done;
        int          polls;
        int          err0;
        r    = rows[idx];
        err0 = errors;
        case (r.op)
            OP_WR: bus_xfer(1'b1, r.adr, r.wdat, rdat);
            OP_RD: begin
                bus_xfer(1'b0, r.adr, 8'h00, rdat);
                check_byte(rdat, r.exp, "read data");
            end
            OP_STAT: begin
                bus_xfer(1'b0, r.adr, 8'h00, rdat);
                check_status(rdat, r.exp);
            end
            OP_WAIT: begin
                // poll until the frame has left the transmitter
                done  = 1'b0;
                polls = 0;
                while (!done && polls < FRAME_CYCLES) begin
                    bus_xfer(1'b0, r.adr, 8'h00, rdat);
                    polls++;
                    done = (rdat[soc_io_pkg::STAT_TX_BUSY] === 1'b0);
                end
                if (done) begin
                    check_status(rdat, r.exp);
                end else begin
                    errors++;
                    $display("transmitter still busy after %0d status polls", polls);
                end
            end
            OP_HOLD: begin
                // a full frame time of status reads
                for (int k = 0; k < FRAME_CYCLES / 2; k++) begin
                    bus_xfer(1'b0, r.adr, 8'h00, rdat);
                    check_status(rdat, r.exp);
                end
            end
            default: check_byte(leds, r.exp, "leds_o");
        endcase
        $display("row %0d %s at %h: %s", idx, op_text(r.op), r.adr,
                 (errors == err0) ? "ok" : "mismatch");
    endtask

    initial begin
        rst_n    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        checks   = 0;
        errors   = 0;
        build_table();
        check_reset_sequence();
        wait (ready === 1'b1);
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end
        $display("summary: %0d rows, %0d checks, %0d errors", n_rows, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
